// ==== include/cache_config.svh ====
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// Word address width, MSB selects controller space
`define CACHE_ADDR_W 12

// Front-end and back-end word
`define CACHE_DATA_W 32
`define CACHE_NBYTES 4

// Direct-mapped geometry
`define CACHE_LINES_W    4  // log2 of line count
`define CACHE_WORD_OFF_W 2  // log2 of words per line

// Write-through buffer depth, log2
`define CACHE_WTB_DEPTH_W 2

// Tag is whatever is left of the cache-space address
`define CACHE_TAG_W (`CACHE_ADDR_W - 1 - `CACHE_LINES_W - `CACHE_WORD_OFF_W)

`endif

// ==== hdl/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

   // Cache memory FSM
   typedef enum logic [1:0] {
      MEM_IDLE   = 2'd0,  // Waiting for a registered request
      MEM_LOOKUP = 2'd1,  // Tag compare, hit answer or write issue
      MEM_REFILL = 2'd2,  // Line fill in progress
      MEM_DONE   = 2'd3   // Return refilled word
   } mem_state_e;

   // Back-end arbiter grant
   typedef enum logic [1:0] {
      BE_NONE   = 2'd0,
      BE_WRITE  = 2'd1,   // Draining one buffered write
      BE_REFILL = 2'd2    // Four word reads for a line
   } be_op_e;

   // Controller registers, decoded from the low address bits
   typedef enum logic [2:0] {
      CTRL_INVALIDATE  = 3'd0,  // Write 1 to drop every line
      CTRL_WTB_EMPTY   = 3'd1,  // Buffer-empty flag in bit 0
      CTRL_READ_HITS   = 3'd2,
      CTRL_READ_MISSES = 3'd3,
      CTRL_CNT_RESET   = 3'd4   // Write 1 to clear both counters
   } ctrl_reg_e;

endpackage

`default_nettype wire

// ==== hdl/cache_be_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_config.svh"

interface cache_be_if;

   // Write channel, one word per transfer
   logic                                       wr_valid;
   logic [`CACHE_ADDR_W-2:0]                   wr_addr;  // Cache-space word address
   logic [`CACHE_DATA_W-1:0]                   wr_data;
   logic [`CACHE_NBYTES-1:0]                   wr_strb;
   logic                                       wr_ready; // Low while buffer full

   // Refill channel, one line per request
   logic                                       rf_valid;
   logic [`CACHE_ADDR_W-2-`CACHE_WORD_OFF_W:0] rf_addr;  // Line address
   logic                                       rf_ready; // Pulses once per word
   logic [`CACHE_DATA_W-1:0]                   rf_data;
   logic                                       rf_last;  // With the fourth word

   // Status from the back end
   logic                                       wtb_empty;

   modport mem (
      output wr_valid, wr_addr, wr_data, wr_strb,
      input  wr_ready,
      output rf_valid, rf_addr,
      input  rf_ready, rf_data, rf_last
   );

   modport be (
      input  wr_valid, wr_addr, wr_data, wr_strb,
      output wr_ready,
      input  rf_valid, rf_addr,
      output rf_ready, rf_data, rf_last,
      output wtb_empty
   );

endinterface

`default_nettype wire

// ==== hdl/cache_front_end.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_config.svh"

module cache_front_end import cache_pkg::*; (
   input  logic                       clk,
   input  logic                       rst_n,
   // Host side
   input  logic                       req,
   input  logic [`CACHE_ADDR_W-1:0]   addr,
   input  logic [`CACHE_DATA_W-1:0]   wdata,
   input  logic [`CACHE_NBYTES-1:0]   wstrb,   // All zero for a read
   output logic [`CACHE_DATA_W-1:0]   rdata,
   output logic                       ack,
   // Cache memory side
   output logic                       mem_req,
   output logic [`CACHE_ADDR_W-2:0]   mem_addr,
   output logic [`CACHE_DATA_W-1:0]   mem_wdata,
   output logic [`CACHE_NBYTES-1:0]   mem_wstrb,
   input  logic [`CACHE_DATA_W-1:0]   mem_rdata,
   input  logic                       mem_ack,
   // Controller side
   output logic                       ctrl_req,
   output ctrl_reg_e                  ctrl_sel,
   output logic [`CACHE_DATA_W-1:0]   ctrl_wdata,
   input  logic [`CACHE_DATA_W-1:0]   ctrl_rdata,
   input  logic                       ctrl_ack
);

   logic                     req_q;    // One-cycle registered request
   logic                     busy_q;   // Request outstanding
   logic [`CACHE_ADDR_W-1:0] addr_q;
   logic [`CACHE_DATA_W-1:0] wdata_q;
   logic [`CACHE_NBYTES-1:0] wstrb_q;
   logic                     accept;

   // A held req is new only once the previous one has been acked
   assign accept = req & (~busy_q | ack);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         req_q  <= 1'b0;
         busy_q <= 1'b0;
      end else begin
         req_q <= accept;
         if (accept)
            busy_q <= 1'b1;
         else if (ack)
            busy_q <= 1'b0;  // Served, idle
      end
   end

   // Request fields stay put until the next accept
   always_ff @(posedge clk) begin
      if (accept) begin
         addr_q  <= addr;
         wdata_q <= wdata;
         wstrb_q <= wstrb;
      end
   end

   // Address MSB picks controller space
   assign mem_req   = req_q & ~addr_q[`CACHE_ADDR_W-1];
   assign ctrl_req  = req_q &  addr_q[`CACHE_ADDR_W-1];
   assign mem_addr  = addr_q[`CACHE_ADDR_W-2:0];
   assign mem_wdata = wdata_q;
   assign mem_wstrb = wstrb_q;
   assign ctrl_sel  = ctrl_reg_e'(addr_q[2:0]);

   // Controller sees write data masked by strobes, a read gives zero
   always_comb begin
      for (int b = 0; b < `CACHE_NBYTES; b++)
         ctrl_wdata[8*b +: 8] = wstrb_q[b] ? wdata_q[8*b +: 8] : 8'h00;
   end

   // Only one side answers a given request
   assign ack   = mem_ack | ctrl_ack;
   assign rdata = ctrl_ack ? ctrl_rdata : mem_rdata;

endmodule

`default_nettype wire

// ==== hdl/cache_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_config.svh"

module cache_memory import cache_pkg::*; (
   input  logic                     clk,
   input  logic                     rst_n,
   // From front end
   input  logic                     mem_req,
   input  logic [`CACHE_ADDR_W-2:0] mem_addr,  // Held until mem_ack
   input  logic [`CACHE_DATA_W-1:0] mem_wdata,
   input  logic [`CACHE_NBYTES-1:0] mem_wstrb,
   output logic [`CACHE_DATA_W-1:0] mem_rdata,
   output logic                     mem_ack,
   // Controller
   input  logic                     invalidate,
   output logic                     read_hit,
   output logic                     read_miss,
   // Back end
   cache_be_if.mem                  be
);

   mem_state_e                         state_q;
   logic [`CACHE_TAG_W-1:0]            addr_tag;
   logic [`CACHE_LINES_W-1:0]          addr_idx;
   logic [`CACHE_WORD_OFF_W-1:0]       addr_off;
   logic [`CACHE_WORD_OFF_W-1:0]       rf_cnt_q;   // Word being filled
   logic                               is_write;
   logic                               hit;

   // Storage
   logic [(1<<`CACHE_LINES_W)-1:0]     valid_q;
   logic [`CACHE_TAG_W-1:0]            tag_mem  [1<<`CACHE_LINES_W];
   logic [`CACHE_DATA_W-1:0]           data_mem [1<<(`CACHE_LINES_W+`CACHE_WORD_OFF_W)];

   assign {addr_tag, addr_idx, addr_off} = mem_addr;
   assign is_write = |mem_wstrb;
   assign hit      = valid_q[addr_idx] && (tag_mem[addr_idx] == addr_tag);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state_q  <= MEM_IDLE;
         rf_cnt_q <= '0;
         valid_q  <= '0;
      end else begin
         if (invalidate)
            valid_q <= '0;              // Drop every line at once
         case (state_q)
            MEM_IDLE:
               if (mem_req) state_q <= MEM_LOOKUP;
            MEM_LOOKUP: begin
               if (is_write) begin
                  if (be.wr_ready) state_q <= MEM_IDLE;   // Else stall on full buffer
               end else if (hit) begin
                  state_q <= MEM_IDLE;
               end else begin
                  state_q  <= MEM_REFILL;   // No allocate on writes, only here
                  rf_cnt_q <= '0;
               end
            end
            MEM_REFILL:
               if (be.rf_ready) begin
                  rf_cnt_q <= rf_cnt_q + 1'b1;
                  if (be.rf_last) begin
                     valid_q[addr_idx] <= 1'b1;
                     state_q           <= MEM_DONE;
                  end
               end
            MEM_DONE:
               state_q <= MEM_IDLE;
            default:
               state_q <= MEM_IDLE;
         endcase
      end
   end

   // Array updates
   always_ff @(posedge clk) begin
      if (state_q == MEM_REFILL && be.rf_ready) begin
         data_mem[{addr_idx, rf_cnt_q}] <= be.rf_data;
         if (be.rf_last)
            tag_mem[addr_idx] <= addr_tag;
      end
      // Write hit merges bytes as the word goes out
      if (be.wr_valid && be.wr_ready && hit) begin
         for (int b = 0; b < `CACHE_NBYTES; b++)
            if (mem_wstrb[b])
               data_mem[{addr_idx, addr_off}][8*b +: 8] <= mem_wdata[8*b +: 8];
      end
   end

   // Front-end answer; DONE reads the word just filled
   assign mem_rdata = data_mem[{addr_idx, addr_off}];
   assign mem_ack   = (state_q == MEM_LOOKUP && (is_write ? be.wr_ready : hit)) ||
                      (state_q == MEM_DONE);

   // Counter events, one cycle each
   assign read_hit  = (state_q == MEM_LOOKUP) && !is_write &&  hit;
   assign read_miss = (state_q == MEM_LOOKUP) && !is_write && !hit;

   // Every write goes through
   assign be.wr_valid = (state_q == MEM_LOOKUP) && is_write;
   assign be.wr_addr  = mem_addr;
   assign be.wr_data  = mem_wdata;
   assign be.wr_strb  = mem_wstrb;

   assign be.rf_valid = (state_q == MEM_REFILL);
   assign be.rf_addr  = {addr_tag, addr_idx};

endmodule

`default_nettype wire

// ==== hdl/cache_back_end.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_config.svh"

module cache_back_end import cache_pkg::*; (
   input  logic                     clk,
   input  logic                     rst_n,
   cache_be_if.be                   be,
   // Memory port
   output logic                     be_req,
   output logic [`CACHE_ADDR_W-2:0] be_addr,
   output logic [`CACHE_DATA_W-1:0] be_wdata,
   output logic [`CACHE_NBYTES-1:0] be_wstrb,
   input  logic [`CACHE_DATA_W-1:0] be_rdata,
   input  logic                     be_ack
);

   be_op_e                           op_q;
   logic [`CACHE_WORD_OFF_W-1:0]     rf_cnt_q;
   // Write-through FIFO
   logic [`CACHE_ADDR_W-2:0]         fifo_addr [1<<`CACHE_WTB_DEPTH_W];
   logic [`CACHE_DATA_W-1:0]         fifo_data [1<<`CACHE_WTB_DEPTH_W];
   logic [`CACHE_NBYTES-1:0]         fifo_strb [1<<`CACHE_WTB_DEPTH_W];
   logic [`CACHE_WTB_DEPTH_W-1:0]    wr_ptr_q, rd_ptr_q;
   logic [`CACHE_WTB_DEPTH_W:0]      level_q;
   logic                             push, pop, empty;

   assign empty       = (level_q == '0);
   assign be.wr_ready = (level_q != (1 << `CACHE_WTB_DEPTH_W));
   assign push        = be.wr_valid & be.wr_ready;
   assign pop         = (op_q == BE_WRITE) & be_ack;  // Entry leaves only when acked
   assign be.wtb_empty = empty;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         level_q  <= '0;
      end else begin
         if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
         if (pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
         level_q <= level_q + push - pop;
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         fifo_addr[wr_ptr_q] <= be.wr_addr;
         fifo_data[wr_ptr_q] <= be.wr_data;
         fifo_strb[wr_ptr_q] <= be.wr_strb;
      end
   end

   // Arbiter, refill only on an empty buffer so memory is current
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         op_q     <= BE_NONE;
         rf_cnt_q <= '0;
      end else begin
         case (op_q)
            BE_NONE:
               if (!empty) begin
                  op_q <= BE_WRITE;
               end else if (be.rf_valid) begin
                  op_q     <= BE_REFILL;
                  rf_cnt_q <= '0;
               end
            BE_WRITE:
               if (be_ack) op_q <= BE_NONE;  // One word per grant
            BE_REFILL:
               if (be_ack) begin
                  rf_cnt_q <= rf_cnt_q + 1'b1;
                  if (be.rf_last) op_q <= BE_NONE;
               end
            default:
               op_q <= BE_NONE;
         endcase
      end
   end

   assign be_req   = (op_q != BE_NONE);
   assign be_addr  = (op_q == BE_REFILL) ? {be.rf_addr, rf_cnt_q} : fifo_addr[rd_ptr_q];
   assign be_wdata = fifo_data[rd_ptr_q];
   assign be_wstrb = (op_q == BE_WRITE) ? fifo_strb[rd_ptr_q] : '0;  // Zero strobe reads

   // Refill words straight through
   assign be.rf_ready = (op_q == BE_REFILL) & be_ack;
   assign be.rf_data  = be_rdata;
   assign be.rf_last  = (op_q == BE_REFILL) && (rf_cnt_q == '1);

endmodule

`default_nettype wire

// ==== hdl/cache_control.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_config.svh"

module cache_control import cache_pkg::*; (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     ctrl_req,
   input  ctrl_reg_e                ctrl_sel,
   input  logic [`CACHE_DATA_W-1:0] ctrl_wdata,  // Zero on reads
   output logic [`CACHE_DATA_W-1:0] ctrl_rdata,
   output logic                     ctrl_ack,
   input  logic                     read_hit,
   input  logic                     read_miss,
   input  logic                     wtb_empty,
   output logic                     invalidate
);

   logic [31:0] hits_q;
   logic [31:0] misses_q;
   logic        cnt_clr;

   // Action registers fire on a write of bit 0
   assign cnt_clr = ctrl_req && (ctrl_sel == CTRL_CNT_RESET) && ctrl_wdata[0];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ctrl_ack   <= 1'b0;
         invalidate <= 1'b0;
         hits_q     <= '0;
         misses_q   <= '0;
      end else begin
         ctrl_ack   <= ctrl_req;
         invalidate <= ctrl_req && (ctrl_sel == CTRL_INVALIDATE) && ctrl_wdata[0];
         if (cnt_clr) begin
            hits_q   <= '0;
            misses_q <= '0;
         end else begin
            hits_q   <= hits_q + read_hit;
            misses_q <= misses_q + read_miss;
         end
      end
   end

   // Read-back mux, only valid with ctrl_ack
   always_ff @(posedge clk) begin
      case (ctrl_sel)
         CTRL_WTB_EMPTY:   ctrl_rdata <= {{(`CACHE_DATA_W-1){1'b0}}, wtb_empty};
         CTRL_READ_HITS:   ctrl_rdata <= hits_q;
         CTRL_READ_MISSES: ctrl_rdata <= misses_q;
         default:          ctrl_rdata <= '0;
      endcase
   end

endmodule

`default_nettype wire

// ==== hdl/cache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_config.svh"

module cache_top import cache_pkg::*; (
   input  logic                     clk,
   input  logic                     rst_n,
   // Processor port
   input  logic                     req,
   input  logic [`CACHE_ADDR_W-1:0] addr,    // Word address, MSB for controller
   input  logic [`CACHE_DATA_W-1:0] wdata,
   input  logic [`CACHE_NBYTES-1:0] wstrb,
   output logic [`CACHE_DATA_W-1:0] rdata,
   output logic                     ack,
   // Memory port
   output logic                     be_req,
   output logic [`CACHE_ADDR_W-2:0] be_addr,
   output logic [`CACHE_DATA_W-1:0] be_wdata,
   output logic [`CACHE_NBYTES-1:0] be_wstrb,
   input  logic [`CACHE_DATA_W-1:0] be_rdata,
   input  logic                     be_ack
);

   // Front end to cache memory
   logic                     mem_req, mem_ack;
   logic [`CACHE_ADDR_W-2:0] mem_addr;
   logic [`CACHE_DATA_W-1:0] mem_wdata, mem_rdata;
   logic [`CACHE_NBYTES-1:0] mem_wstrb;
   // Front end to controller
   logic                     ctrl_req, ctrl_ack;
   ctrl_reg_e                ctrl_sel;
   logic [`CACHE_DATA_W-1:0] ctrl_wdata, ctrl_rdata;
   // Events and control
   logic                     read_hit, read_miss, invalidate;

   cache_be_if be_bus ();

   cache_front_end front_end (
      .clk        (clk),
      .rst_n      (rst_n),
      .req        (req),
      .addr       (addr),
      .wdata      (wdata),
      .wstrb      (wstrb),
      .rdata      (rdata),
      .ack        (ack),
      .mem_req    (mem_req),
      .mem_addr   (mem_addr),
      .mem_wdata  (mem_wdata),
      .mem_wstrb  (mem_wstrb),
      .mem_rdata  (mem_rdata),
      .mem_ack    (mem_ack),
      .ctrl_req   (ctrl_req),
      .ctrl_sel   (ctrl_sel),
      .ctrl_wdata (ctrl_wdata),
      .ctrl_rdata (ctrl_rdata),
      .ctrl_ack   (ctrl_ack)
   );

   cache_memory cache_memory (
      .clk        (clk),
      .rst_n      (rst_n),
      .mem_req    (mem_req),
      .mem_addr   (mem_addr),
      .mem_wdata  (mem_wdata),
      .mem_wstrb  (mem_wstrb),
      .mem_rdata  (mem_rdata),
      .mem_ack    (mem_ack),
      .invalidate (invalidate),
      .read_hit   (read_hit),
      .read_miss  (read_miss),
      .be         (be_bus.mem)
   );

   cache_back_end back_end (
      .clk      (clk),
      .rst_n    (rst_n),
      .be       (be_bus.be),
      .be_req   (be_req),
      .be_addr  (be_addr),
      .be_wdata (be_wdata),
      .be_wstrb (be_wstrb),
      .be_rdata (be_rdata),
      .be_ack   (be_ack)
   );

   cache_control cache_control (
      .clk        (clk),
      .rst_n      (rst_n),
      .ctrl_req   (ctrl_req),
      .ctrl_sel   (ctrl_sel),
      .ctrl_wdata (ctrl_wdata),
      .ctrl_rdata (ctrl_rdata),
      .ctrl_ack   (ctrl_ack),
      .read_hit   (read_hit),
      .read_miss  (read_miss),
      .wtb_empty  (be_bus.wtb_empty),  // Status tapped off the back-end bundle
      .invalidate (invalidate)
   );

endmodule

`default_nettype wire

// ==== verif/cache_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_config.svh"

module cache_sva (
   input logic                     clk,
   input logic                     rst_n,
   input logic                     req,
   input logic [`CACHE_ADDR_W-1:0] addr,
   input logic [`CACHE_DATA_W-1:0] wdata,
   input logic [`CACHE_NBYTES-1:0] wstrb,
   input logic                     ack,
   input logic                     be_req,
   input logic [`CACHE_ADDR_W-2:0] be_addr,
   input logic [`CACHE_DATA_W-1:0] be_wdata,
   input logic [`CACHE_NBYTES-1:0] be_wstrb,
   input logic                     be_ack
);

   int unsigned err_cnt = 0;  // Read by the testbench summary
   logic        pend_q;       // Host request waiting for ack

   // A req still high at the end of the ack cycle is a new request
   always_ff @(posedge clk) begin
      if (!rst_n)
         pend_q <= 1'b0;
      else if (ack)
         pend_q <= req;
      else if (req)
         pend_q <= 1'b1;
   end

   // Host keeps req and fields until ack shows up
   req_hold: assert property (@(posedge clk) disable iff (!rst_n)
      req && !ack |=> ack || (req && $stable(addr) && $stable(wdata) && $stable(wstrb)))
      else begin
         $error("req dropped or changed before ack");
         err_cnt++;
      end

   ack_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      ack |=> !ack)
      else begin
         $error("ack longer than one cycle");
         err_cnt++;
      end

   // Memory request stays put until the word is acked
   be_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
      be_req && !be_ack |=>
         be_req && $stable(be_addr) && $stable(be_wdata) && $stable(be_wstrb))
      else begin
         $error("be_req dropped or changed before be_ack");
         err_cnt++;
      end

   ack_owned: assert property (@(posedge clk) disable iff (!rst_n)
      ack |-> pend_q)
      else begin
         $error("ack with no request outstanding");
         err_cnt++;
      end

endmodule

bind cache_top cache_sva sva_checks (.*);

`default_nettype wire

// ==== verif/cache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_config.svh"

module cache_tb import cache_pkg::*; ();

   localparam int AW         = `CACHE_ADDR_W;
   localparam int DW         = `CACHE_DATA_W;
   localparam int NB         = `CACHE_NBYTES;
   localparam int OFF_W      = `CACHE_WORD_OFF_W;
   localparam int LINES_W    = `CACHE_LINES_W;
   localparam int TAG_W      = `CACHE_TAG_W;
   localparam int NLINES     = 1 << LINES_W;
   localparam int MWORDS     = 1 << (AW - 1);      // Cache-space words
   localparam int N_RAND     = 400;
   localparam int N_OPS      = N_RAND + 80;        // Random plus directed
   localparam int WORST_CYC  = 40;                 // Miss behind a full buffer
   localparam int TIMEOUT_NS = N_OPS * WORST_CYC * 8 + 2000;

   logic          clk = 1'b0;
   logic          rst_n;
   logic          req;
   logic [AW-1:0] addr;
   logic [DW-1:0] wdata;
   logic [NB-1:0] wstrb;
   logic [DW-1:0] rdata;
   logic          ack;
   logic          be_req;
   logic [AW-2:0] be_addr;
   logic [DW-1:0] be_wdata;
   logic [NB-1:0] be_wstrb;
   logic [DW-1:0] be_rdata;
   logic          be_ack;

   // Models
   logic [DW-1:0]       mem_model [MWORDS];   // Memory behind the back end
   logic [DW-1:0]       ref_mem   [MWORDS];   // Expected data, updated at issue
   logic [AW-2+DW+NB:0] wr_exp_q  [$];        // {addr, data, strb} in issue order
   logic [NLINES-1:0]   shadow_valid;
   logic [TAG_W-1:0]    shadow_tag [NLINES];
   logic [31:0]         hit_cnt;
   logic [31:0]         miss_cnt;

   int          value_errs = 0;
   int          other_errs = 0;
   logic [31:0] stim_state = 32'd98730;
   logic [31:0] mem_state  = 32'd98730;
   int          wait_left  = -1;              // No memory word in progress

   cache_top UUT (.*);

   always #4 clk = ~clk;  // 8 ns period

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // Upper LCG bits moved down, low bits of an LCG repeat quickly
   function automatic logic [31:0] stim_rand();
      stim_state = lcg_next(stim_state);
      return {stim_state[15:0], stim_state[31:16]};
   endfunction

   function automatic logic [DW-1:0] fill_word(input int unsigned a);
      return (a * 32'h9E37_79B1) ^ {a[15:0], ~a[15:0]};
   endfunction

   function automatic logic [DW-1:0] merge_bytes(input logic [DW-1:0] old_w,
                                                 input logic [DW-1:0] new_w,
                                                 input logic [NB-1:0] strb);
      logic [DW-1:0] res;
      res = old_w;
      for (int b = 0; b < NB; b++)
         if (strb[b]) res[8*b +: 8] = new_w[8*b +: 8];  // Only enabled lanes
      return res;
   endfunction

   // One word on the memory port, writes checked against issue order
   task automatic serve_word();
      logic [AW-2+DW+NB:0] exp;
      if (be_wstrb != '0) begin
         if (wr_exp_q.size() == 0) begin
            other_errs++;
            $display("Write to %h reached memory with no write outstanding", be_addr);
         end else begin
            exp = wr_exp_q.pop_front();
            assert (be_addr === exp[DW+NB +: AW-1]) else begin
               value_errs++;
               $display("Fail be_addr: got %h, expected %h", be_addr, exp[DW+NB +: AW-1]);
            end
            assert (be_wdata === exp[NB +: DW]) else begin
               value_errs++;
               $display("Fail be_wdata: got %h, expected %h", be_wdata, exp[NB +: DW]);
            end
            assert (be_wstrb === exp[0 +: NB]) else begin
               value_errs++;
               $display("Fail be_wstrb: got %h, expected %h", be_wstrb, exp[0 +: NB]);
            end
         end
         mem_model[be_addr] = merge_bytes(mem_model[be_addr], be_wdata, be_wstrb);
      end else begin
         // Refill must see every earlier write already in memory
         assert (wr_exp_q.size() == 0) else begin
            other_errs++;
            $display("Refill read at %h issued before earlier writes reached memory", be_addr);
         end
         be_rdata = mem_model[be_addr];
      end
   endtask

   // Memory model, random 0 to 3 cycle ack delay per word
   always begin
      @(posedge clk);
      #1;
      be_ack = 1'b0;
      if (rst_n && be_req) begin
         if (wait_left < 0) begin
            mem_state = lcg_next(mem_state);
            wait_left = mem_state[31:30];
         end
         if (wait_left == 0) begin
            serve_word();
            be_ack = 1'b1;
         end
         wait_left--;
      end
   end

   // Single host access, cycles counts edges from req to ack
   task automatic access(input logic [AW-1:0] a, input logic [DW-1:0] wd,
                         input logic [NB-1:0] ws, output logic [DW-1:0] rd,
                         output int cycles);
      @(posedge clk);
      #1;
      req    = 1'b1;
      addr   = a;
      wdata  = wd;
      wstrb  = ws;
      cycles = 0;
      do begin
         @(posedge clk);
         #1;
         cycles++;
      end while (!ack);
      rd  = rdata;
      req = 1'b0;  // Dropped inside the ack cycle
   endtask

   task automatic read_word(input logic [AW-1:0] a);
      logic [LINES_W-1:0] idx;
      logic [TAG_W-1:0]   tag;
      logic               hit;
      logic [DW-1:0]      rd;
      int                 cycles;
      idx = a[OFF_W +: LINES_W];
      tag = a[AW-2 -: TAG_W];
      hit = shadow_valid[idx] && (shadow_tag[idx] == tag);  // Direct mapped
      access(a, '0, '0, rd, cycles);
      assert (rd === ref_mem[a[AW-2:0]]) else begin
         value_errs++;
         $display("Fail rdata at %h: got %h, expected %h", a, rd, ref_mem[a[AW-2:0]]);
      end
      if (hit) begin
         hit_cnt++;
         assert (cycles == 2) else begin
            other_errs++;
            $display("Read hit at %h acked after %0d cycles instead of 2", a, cycles);
         end
      end else begin
         miss_cnt++;
         assert (cycles > 2) else begin
            other_errs++;
            $display("Read miss at %h acked after %0d cycles, too soon for a refill", a, cycles);
         end
         shadow_valid[idx] = 1'b1;  // Refill on read miss only
         shadow_tag[idx]   = tag;
      end
   endtask

   task automatic write_word(input logic [AW-1:0] a, input logic [DW-1:0] wd,
                             input logic [NB-1:0] ws);
      logic [DW-1:0] rd;
      int            cycles;
      ref_mem[a[AW-2:0]] = merge_bytes(ref_mem[a[AW-2:0]], wd, ws);
      wr_exp_q.push_back({a[AW-2:0], wd, ws});
      access(a, wd, ws, rd, cycles);  // No allocate, shadow untouched
   endtask

   task automatic reg_read(input ctrl_reg_e sel, output logic [DW-1:0] val);
      logic [AW-1:0] a;
      int            cycles;
      a        = '0;
      a[AW-1]  = 1'b1;  // Controller space
      a[2:0]   = sel;
      access(a, '0, '0, val, cycles);
      assert (cycles == 2) else begin
         other_errs++;
         $display("Controller read acked after %0d cycles instead of 2", cycles);
      end
   endtask

   task automatic reg_write(input ctrl_reg_e sel, input logic [DW-1:0] val);
      logic [AW-1:0] a;
      logic [DW-1:0] rd;
      int            cycles;
      a       = '0;
      a[AW-1] = 1'b1;
      a[2:0]  = sel;
      access(a, val, '1, rd, cycles);
   endtask

   task automatic compare_counters();
      logic [DW-1:0] v;
      reg_read(CTRL_READ_HITS, v);
      assert (v === hit_cnt) else begin
         value_errs++;
         $display("Fail read_hits: got %h, expected %h", v, hit_cnt);
      end
      reg_read(CTRL_READ_MISSES, v);
      assert (v === miss_cnt) else begin
         value_errs++;
         $display("Fail read_misses: got %h, expected %h", v, miss_cnt);
      end
   endtask

   task automatic clear_counters();
      reg_write(CTRL_CNT_RESET, 32'd1);
      hit_cnt  = '0;
      miss_cnt = '0;
   endtask

   // Watchdog
   initial begin
      #(TIMEOUT_NS);
      $display("Watchdog expired after %0d ns, the DUT stopped answering", TIMEOUT_NS);
      $display("Test failed");
      $finish;
   end

   initial begin
      logic [DW-1:0]     v;
      logic [31:0]       r;
      logic [AW-1:0]     a;
      logic [NB-1:0]     ws;
      logic [NLINES-1:0] cached;
      int                n_cached;
      int                sva_errs;
      rst_n    = 1'b0;
      req      = 1'b0;
      addr     = '0;
      wdata    = '0;
      wstrb    = '0;
      be_rdata = '0;
      be_ack   = 1'b0;
      for (int i = 0; i < MWORDS; i++) begin
         mem_model[i] = fill_word(i);
         ref_mem[i]   = fill_word(i);
      end
      shadow_valid = '0;
      hit_cnt      = '0;
      miss_cnt     = '0;
      repeat (4) @(posedge clk);
      #1 rst_n = 1'b1;

      // Fill, hits, then a merged write hit
      read_word(12'h010);
      read_word(12'h010);
      read_word(12'h013);
      write_word(12'h011, 32'hDEAD_BEEF, 4'b0101);
      read_word(12'h011);
      // Write miss must not allocate the line
      write_word(12'h0A4, 32'h1234_5678, 4'b1111);
      read_word(12'h0A4);
      compare_counters();

      // Random mix on a small window, four tags fight over four lines
      for (int i = 0; i < N_RAND; i++) begin
         r = stim_rand();
         a = {1'b0, 3'b000, r[5:4], 2'b00, r[3:2], r[1:0]};
         case (r[15:8] % 8'd10)
            0, 1, 2, 3, 4, 5: read_word(a);
            6, 7, 8: begin
               ws = (r[19:16] == '0) ? 4'b1000 : r[19:16];
               write_word(a, stim_rand(), ws);
            end
            default: compare_counters();
         endcase
      end
      compare_counters();
      clear_counters();
      compare_counters();  // Both back at zero

      // Invalidate, then every line cached before must miss
      cached = shadow_valid;
      reg_write(CTRL_INVALIDATE, 32'd1);
      shadow_valid = '0;
      clear_counters();
      n_cached = 0;
      for (int l = 0; l < NLINES; l++) begin
         if (cached[l]) begin
            a                    = '0;
            a[AW-2 -: TAG_W]     = shadow_tag[l];
            a[OFF_W +: LINES_W]  = l;
            read_word(a);
            n_cached++;
         end
      end
      if (n_cached == 0) begin
         other_errs++;
         $display("No line was cached before the invalidate");
      end
      compare_counters();

      // Buffer drains once memory acked every write
      write_word(12'h020, 32'hA5A5_0001, 4'b1111);
      write_word(12'h021, 32'hA5A5_0002, 4'b0011);
      write_word(12'h062, 32'hA5A5_0003, 4'b1100);
      while (wr_exp_q.size() != 0)
         @(posedge clk);
      repeat (2) @(posedge clk);
      reg_read(CTRL_WTB_EMPTY, v);
      assert (v === 32'd1) else begin
         value_errs++;
         $display("Fail wtb_empty: got %h, expected %h", v, 32'd1);
      end
      read_word(12'h021);  // Merged bytes through a refill

      repeat (4) @(posedge clk);
      sva_errs = UUT.sva_checks.err_cnt;
      $display("Value errors: %0d, other errors: %0d, assertion failures: %0d",
               value_errs, other_errs, sva_errs);
      if (value_errs == 0 && other_errs == 0 && sva_errs == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+include
hdl/cache_pkg.sv
hdl/cache_be_if.sv
hdl/cache_front_end.sv
hdl/cache_memory.sv
hdl/cache_back_end.sv
hdl/cache_control.sv
hdl/cache_top.sv
verif/cache_sva.sv
verif/cache_tb.sv

// ==== Bender.yml ====
package:
  name: cache_wt

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/cache_pkg.sv
      - hdl/cache_be_if.sv
      - hdl/cache_front_end.sv
      - hdl/cache_memory.sv
      - hdl/cache_back_end.sv
      - hdl/cache_control.sv
      - hdl/cache_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/cache_sva.sv
      - verif/cache_tb.sv
